//--- csr_unit.f
source/csr_pkg.sv
source/csr_control.sv
source/csr_mode_regs.sv
source/csr_timer.sv
source/csr_scratch.sv
source/csr_unit.sv
bench/csr_unit_asserts.sv
bench/csr_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the csr_unit testbench, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module csr_unit_tb -f csr_unit.f \
    -o csr_unit_sim > sim.log 2>&1 &&
    ./obj_dir/csr_unit_sim +verilator+error+limit+1000 >> sim.log 2>&1 ||
    echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

//--- bench/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb
    import csr_pkg::*;
;

    logic        clk = 1'b0;
    logic        reset;
    csr_write_t  wr;
    logic [13:0] rd_num;
    logic [31:0] rd_data;
    excp_info_t  excp;
    logic [7:0]  interrupt;
    logic        llbit_set;
    logic        llbit_value;
    logic        has_int;
    logic [1:0]  plv_out;
    logic [31:0] eentry;
    logic [31:0] era;
    logic [63:0] counter_value;
    logic [31:0] tid;
    logic        llbit;

    int error_count = 0;
    // last written value of each register, masked
    logic [31:0] model [logic [13:0]];

    csr_unit UUT (
        .clk           (clk),
        .reset         (reset),
        .wr            (wr),
        .rd_num        (rd_num),
        .rd_data       (rd_data),
        .excp          (excp),
        .interrupt     (interrupt),
        .llbit_set     (llbit_set),
        .llbit_value   (llbit_value),
        .has_int       (has_int),
        .plv_out       (plv_out),
        .eentry        (eentry),
        .era           (era),
        .counter_value (counter_value),
        .tid           (tid),
        .llbit         (llbit)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] mask_for(input logic [13:0] num);
        case (num)
            CSR_CRMD:   return MASK_CRMD;
            CSR_PRMD:   return MASK_PRMD;
            CSR_ECTL:   return MASK_ECTL;
            CSR_ERA:    return MASK_ERA;
            CSR_EENTRY: return MASK_EENTRY;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return MASK_SAVE;
            CSR_TID:    return MASK_TID;
            CSR_TCFG:   return MASK_TCFG;
            CSR_CNTC:   return MASK_CNTC;
            CSR_LLBCTL: return MASK_LLBCTL;
            default:    return 32'h0;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            error_count++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic write_csr(input logic [13:0] num, input logic [31:0] data);
        wr.en = 1'b1;
        wr.num = num;
        wr.data = data;
        model[num] = data & mask_for(num);
        next_cycle();
        wr.en = 1'b0;
    endtask

    task automatic read_check(input logic [13:0] num, input logic [31:0] exp,
                              input string name);
        rd_num = num;
        #1;
        check_value(name, 64'(rd_data), 64'(exp));
        next_cycle();
    endtask

    task automatic wait_estat_bit(input int bit_pos, input logic value, input int limit,
                                  input string what);
        bit found;
        found = 1'b0;
        rd_num = CSR_ESTAT;
        for (int i = 0; i < limit && !found; i++) begin
            next_cycle();
            if (rd_data[bit_pos] === value) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            error_count++;
            $display("timeout: %s not seen within %0d cycles", what, limit);
        end
    endtask

    task automatic set_llbit();
        llbit_set = 1'b1;
        llbit_value = 1'b1;
        next_cycle();
        llbit_set = 1'b0;
        check_value("llbit", 64'(llbit), 64'd1);
    endtask

    task automatic return_from_exception(input logic [1:0] exp_plv);
        excp.ertn_flush = 1'b1;
        #1;
        check_value("plv_out", 64'(plv_out), 64'(exp_plv));
        next_cycle();
        excp.ertn_flush = 1'b0;
    endtask

    initial begin
        #1000000;
        $display("watchdog expired, the run stalled");
        $display("sim failed");
        $finish;
    end

    initial begin
        int unsigned n;
        csr_num_e    nums [7];
        logic [31:0] era_val;
        logic [8:0]  esub;
        logic [7:0]  irq;
        logic [31:0] k;
        logic [31:0] estat_base;
        logic [63:0] v0;
        logic        hw_any;
        void'($urandom(32'ha423));
        reset = 1'b1;
        wr = '0;
        rd_num = '0;
        excp = '0;
        interrupt = '0;
        llbit_set = 1'b0;
        llbit_value = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // reset values and plain register access
        check_value("has_int", 64'(has_int), 64'd0);
        check_value("plv_out", 64'(plv_out), 64'd0);
        read_check(CSR_CRMD, 32'h1 << CRMD_DA, "crmd after reset");
        nums = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_ERA, CSR_EENTRY};
        for (int i = 0; i < 7; i++) begin
            write_csr(nums[i], $urandom);
        end
        for (int i = 0; i < 7; i++) begin
            read_check(nums[i], model[nums[i]], nums[i].name());
        end
        check_value("tid", 64'(tid), 64'(model[CSR_TID]));
        check_value("eentry", 64'(eentry), 64'(model[CSR_EENTRY]));
        read_check(14'h3ff, 32'h0, "unknown register 0x3ff");
        read_check(CSR_TICLR, 32'h0, "ticlr");

        // exception entry from level 3 with interrupts on
        write_csr(CSR_CRMD, 32'h0000_000f);
        era_val = $urandom;
        esub = 9'($urandom);
        excp.era = era_val;
        excp.ecode = EXC_SYS;
        excp.esubcode = esub;
        excp.excp_flush = 1'b1;
        #1;
        check_value("plv_out", 64'(plv_out), 64'd0);
        next_cycle();
        excp.excp_flush = 1'b0;
        read_check(CSR_PRMD, 32'h7, "prmd after entry");
        read_check(CSR_CRMD, 32'h8, "crmd after entry");
        check_value("era", 64'(era), 64'(era_val));
        estat_base = (32'(esub) << ESTAT_ESUBCODE_LSB) | (32'(EXC_SYS) << ESTAT_ECODE_LSB);
        read_check(CSR_ESTAT, estat_base, "estat after entry");

        // return, first with KLO clear, then with KLO set
        set_llbit();
        write_csr(CSR_LLBCTL, 32'h0);
        return_from_exception(2'd3);
        read_check(CSR_CRMD, 32'hf, "crmd after return");
        check_value("llbit", 64'(llbit), 64'd0);
        set_llbit();
        write_csr(CSR_LLBCTL, 32'h1 << LLBCTL_KLO);
        read_check(CSR_LLBCTL, 32'h5, "llbctl with klo");
        return_from_exception(2'd3);
        check_value("llbit", 64'(llbit), 64'd1);
        read_check(CSR_LLBCTL, 32'h1, "llbctl after return");

        // one-shot timer, IE is back on after the return
        write_csr(CSR_ECTL, 32'h1 << ESTAT_TI);
        n = $urandom_range(24, 3);
        write_csr(CSR_TCFG, (n << TCFG_INITVAL_LSB) | (32'h1 << TCFG_EN));
        wait_estat_bit(ESTAT_TI, 1'b1, int'(4 * n + 4), "timer interrupt");
        check_value("has_int", 64'(has_int), 64'd1);
        write_csr(CSR_TICLR, 32'h1 << TICLR_CLR);
        read_check(CSR_ESTAT, estat_base, "estat after ticlr");
        check_value("has_int", 64'(has_int), 64'd0);

        // hardware lines
        write_csr(CSR_ECTL, 32'hff << ESTAT_IS_HW_LSB);
        irq = 8'($urandom) | 8'h01;
        interrupt = irq;
        next_cycle();
        read_check(CSR_ESTAT, estat_base | (32'(irq) << ESTAT_IS_HW_LSB), "estat hw lines");
        hw_any = |(model[CSR_ECTL] & (32'(irq) << ESTAT_IS_HW_LSB) & 32'h1fff);
        check_value("has_int", 64'(has_int), 64'(model[CSR_CRMD][CRMD_IE] & hw_any));
        write_csr(CSR_ECTL, 32'h3);
        check_value("has_int", 64'(has_int), 64'd0);
        interrupt = 8'h00;
        next_cycle();

        // stable counter and its offset
        v0 = counter_value;
        next_cycle();
        check_value("counter_value", counter_value, v0 + 64'd1);
        k = $urandom;
        v0 = counter_value;
        write_csr(CSR_CNTC, k);
        check_value("counter_value", counter_value, v0 + {{32{k[31]}}, k} + 64'd1);
        next_cycle();

        $display("check errors: %0d, assertion failures: %0d",
                 error_count, UUT.u_asserts.fail_count);
        if (error_count == 0 && UUT.u_asserts.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- bench/csr_unit_asserts.sv
`timescale 1ns/1ps

module csr_unit_asserts
    import csr_pkg::*;
#(
    parameter int COUNTER_WIDTH = 64
) (
    input logic                     clk,
    input logic                     reset,
    input csr_strobe_t              strobe,
    input excp_info_t               excp,
    input logic [7:0]               interrupt,
    input mode_view_t               mode,
    input timer_view_t              timer,
    input scratch_view_t            scratch,
    input logic                     has_int,
    input logic [1:0]               plv_out,
    input logic [31:0]              era,
    input logic                     llbit,
    input logic [COUNTER_WIDTH-1:0] counter_value
);

    int fail_count = 0;

    plv_on_entry: assert property (@(posedge clk) disable iff (reset)
        excp.excp_flush |-> plv_out == 2'b00)
        else begin
            fail_count++;
            $error("plv_out is not zero in the exception entry cycle");
        end

    // forwarded level is the level crmd takes next
    plv_matches_next: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> mode.crmd[CRMD_PLV_LSB +: 2] == $past(plv_out))
        else begin
            fail_count++;
            $error("CRMD.PLV differs from the level forwarded one cycle before");
        end

    // plv and ie move into prmd, crmd drops to level 0
    entry_state: assert property (@(posedge clk) disable iff (reset)
        $past(excp.excp_flush) |-> mode.crmd[2:0] == 3'b000 &&
            mode.prmd[2:0] == $past(mode.crmd[2:0]) && era == $past(excp.era))
        else begin
            fail_count++;
            $error("CRMD, PRMD or ERA wrong after exception entry");
        end

    return_state: assert property (@(posedge clk) disable iff (reset)
        $past(excp.ertn_flush && !excp.excp_flush) |->
            mode.crmd[2:0] == $past(mode.prmd[2:0]))
        else begin
            fail_count++;
            $error("CRMD not restored from PRMD after return");
        end

    llbit_on_return: assert property (@(posedge clk) disable iff (reset)
        $past(excp.ertn_flush && !excp.excp_flush && !scratch.llbctl[LLBCTL_KLO]) |-> !llbit)
        else begin
            fail_count++;
            $error("llbit survived a return with KLO clear");
        end

    hw_lines: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> mode.estat[9:2] == $past(interrupt))
        else begin
            fail_count++;
            $error("ESTAT hardware bits do not match the lines of the previous cycle");
        end

    pending_on_zero: assert property (@(posedge clk) disable iff (reset)
        $rose(timer.pending) |-> $past(timer.tval) == 32'h0)
        else begin
            fail_count++;
            $error("timer pending bit rose although TVAL was not zero");
        end

    ticlr_clears: assert property (@(posedge clk) disable iff (reset)
        $past(strobe.ticlr && strobe.data[TICLR_CLR]) |-> !timer.pending)
        else begin
            fail_count++;
            $error("timer pending bit still set after a TICLR clear");
        end

    hw_request: assert property (@(posedge clk) disable iff (reset)
        mode.crmd[CRMD_IE] && (|(mode.ectl[9:2] & $past(interrupt))) |-> has_int)
        else begin
            fail_count++;
            $error("has_int low although an enabled hardware line was raised");
        end

    counter_step: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) && !$past(strobe.cntc) |->
            counter_value == $past(counter_value) + COUNTER_WIDTH'(1))
        else begin
            fail_count++;
            $error("stable counter did not advance by one");
        end

endmodule

bind csr_unit csr_unit_asserts #(
    .COUNTER_WIDTH (COUNTER_WIDTH)
) u_asserts (
    .clk           (clk),
    .reset         (reset),
    .strobe        (strobe),
    .excp          (excp),
    .interrupt     (interrupt),
    .mode          (mode),
    .timer         (timer),
    .scratch       (scratch),
    .has_int       (has_int),
    .plv_out       (plv_out),
    .era           (era),
    .llbit         (llbit),
    .counter_value (counter_value)
);

//--- source/csr_unit.sv
`timescale 1ns/1ps

module csr_unit
    import csr_pkg::*;
#(
    parameter int COUNTER_WIDTH = 64
) (
    input  logic                     clk,
    input  logic                     reset,
    input  csr_write_t               wr,
    input  logic [13:0]              rd_num,
    output logic [31:0]              rd_data,
    input  excp_info_t               excp,
    input  logic [7:0]               interrupt,
    input  logic                     llbit_set,
    input  logic                     llbit_value,
    output logic                     has_int,
    output logic [1:0]               plv_out,
    output logic [31:0]              eentry,
    output logic [31:0]              era,
    output logic [COUNTER_WIDTH-1:0] counter_value,
    output logic [31:0]              tid,
    output logic                     llbit
);

    csr_strobe_t   strobe;
    mode_view_t    mode;
    timer_view_t   timer;
    scratch_view_t scratch;
    logic          timer_pending;

    csr_control u_control (
        .wr      (wr),
        .rd_num  (rd_num),
        .mode    (mode),
        .timer   (timer),
        .scratch (scratch),
        .strobe  (strobe),
        .rd_data (rd_data)
    );

    csr_mode_regs u_mode_regs (
        .clk           (clk),
        .reset         (reset),
        .strobe        (strobe),
        .excp          (excp),
        .interrupt     (interrupt),
        .timer_pending (timer_pending),
        .mode          (mode),
        .has_int       (has_int),
        .plv_out       (plv_out),
        .eentry        (eentry),
        .era           (era)
    );

    csr_timer #(
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) u_timer (
        .clk           (clk),
        .reset         (reset),
        .strobe        (strobe),
        .timer         (timer),
        .timer_pending (timer_pending),
        .counter_value (counter_value)
    );

    csr_scratch u_scratch (
        .clk         (clk),
        .reset       (reset),
        .strobe      (strobe),
        .excp        (excp),
        .llbit_set   (llbit_set),
        .llbit_value (llbit_value),
        .scratch     (scratch),
        .llbit       (llbit),
        .tid         (tid)
    );

endmodule

//--- source/csr_scratch.sv
`timescale 1ns/1ps

module csr_scratch
    import csr_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  csr_strobe_t   strobe,
    input  excp_info_t    excp,
    input  logic          llbit_set,
    input  logic          llbit_value,
    output scratch_view_t scratch,
    output logic          llbit,
    output logic [31:0]   tid
);

    logic [3:0][31:0] save;
    logic [31:0]      tid_q;
    logic [31:0]      llbctl;
    logic             llbit_q;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (strobe.save[i]) begin
                save[i] <= strobe.data & MASK_SAVE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tid_q <= '0;
        end else if (strobe.tid) begin
            tid_q <= strobe.data & MASK_TID;
        end
    end

    // klo keeps llbit across exactly one return
    always_ff @(posedge clk) begin
        if (reset) begin
            llbctl <= '0;
            llbit_q <= 1'b0;
        end else if (excp.ertn_flush) begin
            if (llbctl[LLBCTL_KLO]) begin
                llbctl[LLBCTL_KLO] <= 1'b0;
            end else begin
                llbit_q <= 1'b0;
            end
        end else if (strobe.llbctl && strobe.data[LLBCTL_WCLLB]) begin
            llbctl <= strobe.data & MASK_LLBCTL;
            llbit_q <= 1'b0;
        end else begin
            if (strobe.llbctl) begin
                llbctl <= strobe.data & MASK_LLBCTL;
            end
            if (llbit_set) begin
                llbit_q <= llbit_value;
            end
        end
    end

    assign scratch = '{save: save, tid: tid_q, llbctl: {llbctl[31:1], llbit_q}};
    assign llbit = llbit_q;
    assign tid = tid_q;

endmodule

//--- source/csr_timer.sv
`timescale 1ns/1ps

module csr_timer
    import csr_pkg::*;
#(
    parameter int COUNTER_WIDTH = 64
) (
    input  logic                     clk,
    input  logic                     reset,
    input  csr_strobe_t              strobe,
    output timer_view_t              timer,
    output logic                     timer_pending,
    output logic [COUNTER_WIDTH-1:0] counter_value
);

    logic [31:0]              tcfg;
    logic [31:0]              tval;
    logic                     timer_en;
    logic                     pending;
    logic [31:0]              cntc;
    logic [COUNTER_WIDTH-1:0] counter;
    logic                     expire;
    logic                     ticlr_clear;
    logic [31:0]              reload;

    assign expire = timer_en && (tval == '0);
    assign ticlr_clear = strobe.ticlr && (|(strobe.data & MASK_TICLR));
    assign reload = {tcfg[TCFG_INITVAL_LSB +: 30], 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg <= '0;
            tval <= '0;
            timer_en <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (strobe.tcfg) begin
                tcfg <= strobe.data & MASK_TCFG;
                tval <= {strobe.data[TCFG_INITVAL_LSB +: 30], 2'b00};
                timer_en <= strobe.data[TCFG_EN];
            end else if (expire) begin
                // one-shot parks at all ones and stops
                tval <= tcfg[TCFG_PERIODIC] ? reload : '1;
                timer_en <= tcfg[TCFG_PERIODIC];
            end else if (timer_en) begin
                tval <= tval - 32'd1;
            end
            // clear beats a new expiry
            if (ticlr_clear) begin
                pending <= 1'b0;
            end else if (expire) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cntc <= '0;
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
            if (strobe.cntc) begin
                cntc <= strobe.data & MASK_CNTC;
            end
        end
    end

    assign counter_value = counter + COUNTER_WIDTH'(signed'(cntc));

    assign timer = '{tcfg: tcfg, tval: tval, pending: pending};
    assign timer_pending = pending;

endmodule

//--- source/csr_mode_regs.sv
`timescale 1ns/1ps

module csr_mode_regs
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  csr_strobe_t strobe,
    input  excp_info_t  excp,
    input  logic [7:0]  interrupt,
    input  logic        timer_pending,
    output mode_view_t  mode,
    output logic        has_int,
    output logic [1:0]  plv_out,
    output logic [31:0] eentry,
    output logic [31:0] era
);

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] ectl;
    logic [31:0] badv;
    logic [31:0] eentry_q;
    logic [31:0] era_q;
    logic [1:0]  is_sw;
    logic [7:0]  is_hw;
    exc_code_e   ecode;
    logic [8:0]  esubcode;
    logic [31:0] estat;

    // exception entry wins over return, return over a write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= 32'h1 << CRMD_DA;
        end else if (excp.excp_flush) begin
            crmd[CRMD_PLV_LSB +: 2] <= 2'b00;
            crmd[CRMD_IE] <= 1'b0;
        end else if (excp.ertn_flush) begin
            crmd[CRMD_PLV_LSB +: 2] <= prmd[PRMD_PPLV_LSB +: 2];
            crmd[CRMD_IE] <= prmd[PRMD_PIE];
        end else if (strobe.crmd) begin
            crmd <= strobe.data & MASK_CRMD;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= '0;
        end else if (excp.excp_flush) begin
            prmd[PRMD_PPLV_LSB +: 2] <= crmd[CRMD_PLV_LSB +: 2];
            prmd[PRMD_PIE] <= crmd[CRMD_IE];
        end else if (strobe.prmd) begin
            prmd <= strobe.data & MASK_PRMD;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ectl <= '0;
            eentry_q <= '0;
        end else begin
            if (strobe.ectl) begin
                ectl <= strobe.data & MASK_ECTL;
            end
            if (strobe.eentry) begin
                eentry_q <= strobe.data & MASK_EENTRY;
            end
        end
    end

    // hardware lines are sampled every cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            is_sw <= '0;
            is_hw <= '0;
            ecode <= EXC_INT;
            esubcode <= '0;
        end else begin
            is_hw <= interrupt;
            if (excp.excp_flush) begin
                ecode <= excp.ecode;
                esubcode <= excp.esubcode;
            end else if (strobe.estat) begin
                is_sw <= strobe.data[ESTAT_IS_SW_LSB +: 2];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excp.excp_flush) begin
            era_q <= excp.era;
        end else if (strobe.era) begin
            era_q <= strobe.data & MASK_ERA;
        end
        if (excp.excp_flush && excp.va_error) begin
            badv <= excp.bad_va;
        end else if (strobe.badv) begin
            badv <= strobe.data & MASK_BADV;
        end
    end

    always_comb begin
        estat = '0;
        estat[ESTAT_IS_SW_LSB +: 2] = is_sw;
        estat[ESTAT_IS_HW_LSB +: 8] = is_hw;
        estat[ESTAT_TI] = timer_pending;
        estat[ESTAT_ECODE_LSB +: 6] = ecode;
        estat[ESTAT_ESUBCODE_LSB +: 9] = esubcode;
    end

    // forwarded level for the fetch side
    always_comb begin
        if (excp.excp_flush) begin
            plv_out = 2'b00;
        end else if (excp.ertn_flush) begin
            plv_out = prmd[PRMD_PPLV_LSB +: 2];
        end else if (strobe.crmd) begin
            plv_out = strobe.data[CRMD_PLV_LSB +: 2];
        end else begin
            plv_out = crmd[CRMD_PLV_LSB +: 2];
        end
    end

    assign has_int = crmd[CRMD_IE] & (|(ectl[12:0] & estat[12:0]));

    assign mode = '{crmd: crmd, prmd: prmd, ectl: ectl, estat: estat,
                    era: era_q, badv: badv, eentry: eentry_q};
    assign eentry = eentry_q;
    assign era = era_q;

endmodule

//--- source/csr_control.sv
`timescale 1ns/1ps

module csr_control
    import csr_pkg::*;
(
    input  csr_write_t    wr,
    input  logic [13:0]   rd_num,
    input  mode_view_t    mode,
    input  timer_view_t   timer,
    input  scratch_view_t scratch,
    output csr_strobe_t   strobe,
    output logic [31:0]   rd_data
);

    // write decode, one strobe at most
    always_comb begin
        strobe = '0;
        strobe.data = wr.data;
        if (wr.en) begin
            case (wr.num)
                CSR_CRMD:   strobe.crmd = 1'b1;
                CSR_PRMD:   strobe.prmd = 1'b1;
                CSR_ECTL:   strobe.ectl = 1'b1;
                CSR_ESTAT:  strobe.estat = 1'b1;
                CSR_ERA:    strobe.era = 1'b1;
                CSR_BADV:   strobe.badv = 1'b1;
                CSR_EENTRY: strobe.eentry = 1'b1;
                CSR_SAVE0:  strobe.save[0] = 1'b1;
                CSR_SAVE1:  strobe.save[1] = 1'b1;
                CSR_SAVE2:  strobe.save[2] = 1'b1;
                CSR_SAVE3:  strobe.save[3] = 1'b1;
                CSR_TID:    strobe.tid = 1'b1;
                CSR_TCFG:   strobe.tcfg = 1'b1;
                CSR_CNTC:   strobe.cntc = 1'b1;
                CSR_TICLR:  strobe.ticlr = 1'b1;
                CSR_LLBCTL: strobe.llbctl = 1'b1;
                default:    ;
            endcase
        end
    end

    // read mux, ticlr and cntc fall to zero with unknown numbers
    always_comb begin
        case (rd_num)
            CSR_CRMD:   rd_data = mode.crmd;
            CSR_PRMD:   rd_data = mode.prmd;
            CSR_ECTL:   rd_data = mode.ectl;
            CSR_ESTAT:  rd_data = mode.estat;
            CSR_ERA:    rd_data = mode.era;
            CSR_BADV:   rd_data = mode.badv;
            CSR_EENTRY: rd_data = mode.eentry;
            CSR_SAVE0:  rd_data = scratch.save[0];
            CSR_SAVE1:  rd_data = scratch.save[1];
            CSR_SAVE2:  rd_data = scratch.save[2];
            CSR_SAVE3:  rd_data = scratch.save[3];
            CSR_TID:    rd_data = scratch.tid;
            CSR_TCFG:   rd_data = timer.tcfg;
            CSR_TVAL:   rd_data = timer.tval;
            CSR_LLBCTL: rd_data = scratch.llbctl;
            default:    rd_data = '0;
        endcase
    end

endmodule

//--- source/csr_pkg.sv
package csr_pkg;

    typedef enum logic [13:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECTL   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_CNTC   = 14'h043,
        CSR_TICLR  = 14'h044,
        CSR_LLBCTL = 14'h060
    } csr_num_e;

    // other codes are carried as raw 6-bit values
    typedef enum logic [5:0] {
        EXC_INT = 6'h00,
        EXC_SYS = 6'h0b,
        EXC_BRK = 6'h0c
    } exc_code_e;

    localparam int CRMD_PLV_LSB       = 0;
    localparam int CRMD_IE            = 2;
    localparam int CRMD_DA            = 3;
    localparam int CRMD_PG            = 4;
    localparam int CRMD_DATF_LSB      = 5;
    localparam int CRMD_DATM_LSB      = 7;
    localparam int PRMD_PPLV_LSB      = 0;
    localparam int PRMD_PIE           = 2;
    localparam int ESTAT_IS_SW_LSB    = 0;
    localparam int ESTAT_IS_HW_LSB    = 2;
    localparam int ESTAT_TI           = 11;
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int TCFG_EN            = 0;
    localparam int TCFG_PERIODIC      = 1;
    localparam int TCFG_INITVAL_LSB   = 2;
    localparam int LLBCTL_WCLLB       = 1;
    localparam int LLBCTL_KLO         = 2;
    localparam int TICLR_CLR          = 0;

    localparam logic [31:0] MASK_CRMD = (32'h3 << CRMD_PLV_LSB) | (32'h1 << CRMD_IE) |
                                        (32'h1 << CRMD_DA) | (32'h1 << CRMD_PG) |
                                        (32'h3 << CRMD_DATF_LSB) | (32'h3 << CRMD_DATM_LSB);
    localparam logic [31:0] MASK_PRMD   = (32'h3 << PRMD_PPLV_LSB) | (32'h1 << PRMD_PIE);
    // local interrupt enables, bit 10 is reserved
    localparam logic [31:0] MASK_ECTL   = 32'h0000_1bff;
    localparam logic [31:0] MASK_ESTAT  = 32'h3 << ESTAT_IS_SW_LSB;
    localparam logic [31:0] MASK_ERA    = 32'hffff_ffff;
    localparam logic [31:0] MASK_BADV   = 32'hffff_ffff;
    localparam logic [31:0] MASK_EENTRY = 32'hffff_ffc0;
    localparam logic [31:0] MASK_SAVE   = 32'hffff_ffff;
    localparam logic [31:0] MASK_TID    = 32'hffff_ffff;
    localparam logic [31:0] MASK_TCFG   = (32'h1 << TCFG_EN) | (32'h1 << TCFG_PERIODIC) |
                                          (32'h3fff_ffff << TCFG_INITVAL_LSB);
    localparam logic [31:0] MASK_CNTC   = 32'hffff_ffff;
    localparam logic [31:0] MASK_TICLR  = 32'h1 << TICLR_CLR;
    localparam logic [31:0] MASK_LLBCTL = 32'h1 << LLBCTL_KLO;

    typedef struct packed {
        logic        en;
        logic [13:0] num;
        logic [31:0] data;
    } csr_write_t;

    typedef struct packed {
        logic        crmd;
        logic        prmd;
        logic        ectl;
        logic        estat;
        logic        era;
        logic        badv;
        logic        eentry;
        logic [3:0]  save;
        logic        tid;
        logic        tcfg;
        logic        cntc;
        logic        ticlr;
        logic        llbctl;
        logic [31:0] data;
    } csr_strobe_t;

    typedef struct packed {
        logic        excp_flush;
        logic        ertn_flush;
        logic [31:0] era;
        exc_code_e   ecode;
        logic [8:0]  esubcode;
        logic        va_error;
        logic [31:0] bad_va;
    } excp_info_t;

    typedef struct packed {
        logic [31:0] crmd;
        logic [31:0] prmd;
        logic [31:0] ectl;
        logic [31:0] estat;
        logic [31:0] era;
        logic [31:0] badv;
        logic [31:0] eentry;
    } mode_view_t;

    typedef struct packed {
        logic [31:0] tcfg;
        logic [31:0] tval;
        logic        pending;
    } timer_view_t;

    typedef struct packed {
        logic [3:0][31:0] save;
        logic [31:0]      tid;
        logic [31:0]      llbctl;
    } scratch_view_t;

endpackage
